//--- common/actPkg.sv
/*
 * Shared widths, word types, register map and loop-order encoding for the
 * activation-fetch controller. Referenced by scoped names only.
 */
`default_nettype none

package actPkg;

    // ====================
    // Widths and sizes
    // ====================
    localparam int LEN_W     = 4;   // Row length, activation and row counters
    localparam int BLK_W     = 4;
    localparam int FRM_W     = 4;
    localparam int PAT_W     = 4;
    localparam int GRP_W     = 4;
    localparam int ADDR_W    = 8;
    localparam int DATA_W    = 16;
    localparam int MEM_DEPTH = 256;
    localparam int CFG_W     = 8;   // Config write data

    // Counts hold real value minus 1
    typedef logic [LEN_W-1:0]  lenT;
    typedef logic [BLK_W-1:0]  blkT;
    typedef logic [FRM_W-1:0]  frmT;
    typedef logic [PAT_W-1:0]  patT;
    typedef logic [GRP_W-1:0]  grpT;
    typedef logic [ADDR_W-1:0] addrT;
    typedef logic [DATA_W-1:0] actT;

    // Which of the two outer loops runs fastest
    typedef enum logic {
        PATCH_INNER  = 1'b0,
        FTRGRP_INNER = 1'b1
    } loopOrderT;

    // ====================
    // Register map
    // ====================
    localparam logic [2:0] REG_LEN_ROW  = 3'd0;
    localparam logic [2:0] REG_NUM_BLK  = 3'd1;
    localparam logic [2:0] REG_NUM_FRM  = 3'd2;
    localparam logic [2:0] REG_NUM_PAT  = 3'd3;
    localparam logic [2:0] REG_NUM_GRP  = 3'd4;
    localparam logic [2:0] REG_LOOP_ORD = 3'd5; // Highest valid address

endpackage

`default_nettype wire

//--- src/cfgRegs.sv
/*
 * Layer configuration registers behind a simple write port.
 * Fields feed the loop controller as levels and are frozen while a layer runs.
 */
`timescale 1ns/1ps
`default_nettype none

module cfgRegs (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     cfgWe,
    input  wire logic [2:0]               cfgAddr,
    input  wire logic [actPkg::CFG_W-1:0] cfgWdata,
    input  wire logic                     busy,
    output actPkg::lenT                   lenRow,
    output actPkg::blkT                   numBlk,
    output actPkg::frmT                   numFrm,
    output actPkg::patT                   numPat,
    output actPkg::grpT                   numGrp,
    output actPkg::loopOrderT             loopOrder
);

    logic wrEn;

    assign wrEn = cfgWe && !busy; // Locked during a layer

    // ====================
    // Field registers
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lenRow    <= '0;
            numBlk    <= '0;
            numFrm    <= '0;
            numPat    <= '0;
            numGrp    <= '0;
            loopOrder <= actPkg::PATCH_INNER;
        end else if (wrEn) begin
            case (cfgAddr)
                actPkg::REG_LEN_ROW: begin
                    lenRow <= cfgWdata[actPkg::LEN_W-1:0];
                end
                actPkg::REG_NUM_BLK: begin
                    numBlk <= cfgWdata[actPkg::BLK_W-1:0];
                end
                actPkg::REG_NUM_FRM: begin
                    numFrm <= cfgWdata[actPkg::FRM_W-1:0];
                end
                actPkg::REG_NUM_PAT: begin
                    numPat <= cfgWdata[actPkg::PAT_W-1:0];
                end
                actPkg::REG_NUM_GRP: begin
                    numGrp <= cfgWdata[actPkg::GRP_W-1:0];
                end
                actPkg::REG_LOOP_ORD: begin
                    loopOrder <= actPkg::loopOrderT'(cfgWdata[0]); // Bit 0 only
                end
                default: begin
                    // Unmapped address, nothing stored
                end
            endcase
        end
    end

    // Host must stay inside the register map
    addrInMap: assert property (
        @(posedge clk) disable iff (!rst_n)
        cfgWe |-> (cfgAddr <= actPkg::REG_LOOP_ORD)
    );

endmodule

`default_nettype wire

//--- ctrlAct/actLoopCtrl.sv
/*
 * Activation loop controller. Walks the row, block, frame and outer loop counters
 * on every returned activation and decodes the array and pooling position strobes.
 */
`timescale 1ns/1ps
`default_nettype none

module actLoopCtrl (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               sta,
    input  wire logic               getAct,
    input  wire actPkg::lenT        lenRow,
    input  wire actPkg::blkT        numBlk,
    input  wire actPkg::frmT        numFrm,
    input  wire actPkg::patT        numPat,
    input  wire actPkg::grpT        numGrp,
    input  wire actPkg::loopOrderT  loopOrder,
    output logic                    plsFetch,
    output logic                    busy,
    output logic                    frtActRow,
    output logic                    lstActRow,
    output logic                    lstActBlk,
    output logic                    valCol,
    output logic                    valPsum,
    output logic                    frtBlk,
    output logic                    fnhFrm,
    output logic                    evenFrm,
    output logic                    poolEn,
    output logic                    poolValDelta,
    output logic                    poolValFrm,
    output logic                    nextPatch,
    output logic                    nextFtrGrp,
    output logic                    layerDone
);

    actPkg::lenT cntAct;
    actPkg::lenT cntRow;
    actPkg::blkT cntBlk;
    actPkg::frmT cntFrm;
    actPkg::patT cntPat;
    actPkg::grpT cntGrp;

    logic staOk;
    logic frtActBlk;
    logic lstActFrm;
    logic lstActTile;
    logic lstActLay;
    logic patLast;
    logic grpLast;
    logic tileEnd;
    logic patchStep;

    // ====================
    // Position decode
    // ====================
    assign frtActRow = (cntAct == '0);
    assign lstActRow = (cntAct == lenRow);
    assign valCol    = (cntAct >= 2);
    assign valPsum   = (cntRow >= 2);           // First two rows only prime the array
    assign frtActBlk = (cntRow == '0) && frtActRow;
    assign lstActBlk = (cntRow == lenRow) && lstActRow;
    assign frtBlk    = (cntBlk == '0);
    assign lstActFrm = (cntBlk == numBlk) && lstActBlk;

    assign evenFrm      = !cntFrm[0];
    assign poolValDelta = (cntFrm >= 2);
    assign poolValFrm   = !cntFrm[0] && (cntFrm >= 2);
    assign poolEn       = frtActBlk && !frtBlk && (cntFrm != '0);

    assign lstActTile = (cntFrm == numFrm) && lstActFrm;
    assign patLast    = (cntPat == numPat);
    assign grpLast    = (cntGrp == numGrp);
    assign lstActLay  = lstActTile && patLast && grpLast;
    assign tileEnd    = getAct && lstActTile;

    // High when the patch index moves at this tile boundary
    assign patchStep = (loopOrder == actPkg::PATCH_INNER) ? !patLast : grpLast;

    // Fetch request stream
    assign staOk    = sta && !busy;             // Restart while running is dropped
    assign plsFetch = staOk || (getAct && !lstActLay);

    // ====================
    // Inner counters
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cntAct <= '0;
            cntRow <= '0;
            cntBlk <= '0;
            cntFrm <= '0;
        end else if (getAct) begin
            cntAct <= lstActRow ? '0 : cntAct + 1'b1;
            if (lstActBlk) begin
                cntRow <= '0;
            end else if (lstActRow) begin
                cntRow <= cntRow + 1'b1;
            end
            if (lstActFrm) begin
                cntBlk <= '0;
            end else if (lstActBlk) begin
                cntBlk <= cntBlk + 1'b1;
            end
            if (lstActTile) begin
                cntFrm <= '0;
            end else if (lstActFrm) begin
                cntFrm <= cntFrm + 1'b1;
            end
        end
    end

    // Patch and filter-group loops, order from config
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cntPat <= '0;
            cntGrp <= '0;
        end else if (tileEnd) begin
            if (lstActLay) begin
                cntPat <= '0;
                cntGrp <= '0;
            end else if (patchStep) begin
                cntPat <= cntPat + 1'b1;
                if (loopOrder == actPkg::FTRGRP_INNER) begin
                    cntGrp <= '0;               // Inner group loop wraps
                end
            end else begin
                cntGrp <= cntGrp + 1'b1;
                if (loopOrder == actPkg::PATCH_INNER) begin
                    cntPat <= '0;               // Inner patch loop wraps
                end
            end
        end
    end

    // ====================
    // Layer state and pulses
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            fnhFrm     <= 1'b0;
            nextPatch  <= 1'b0;
            nextFtrGrp <= 1'b0;
            layerDone  <= 1'b0;
        end else begin
            if (staOk) begin
                busy <= 1'b1;
            end else if (getAct && lstActLay) begin
                busy <= 1'b0;                   // Drops with layerDone
            end
            fnhFrm     <= getAct && lstActFrm && !lstActLay; // Ping-pong swap point
            nextPatch  <= tileEnd && !lstActLay && patchStep;
            nextFtrGrp <= tileEnd && !lstActLay && !patchStep;
            layerDone  <= getAct && lstActLay;
        end
    end

    // Answers only come back for requests issued inside a layer
    actOnlyWhenBusy: assert property (
        @(posedge clk) disable iff (!rst_n)
        getAct |-> busy
    );

    tilePulseOneHot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({nextPatch, nextFtrGrp, layerDone})
    );

endmodule

`default_nettype wire

//--- src/actFetch.sv
/*
 * Activation fetch unit. Holds the local activation memory, loaded from outside,
 * and answers each fetch request with the next word one cycle later.
 */
`timescale 1ns/1ps
`default_nettype none

module actFetch (
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  wire logic         sta,
    input  wire logic         plsFetch,
    input  wire logic         memWe,
    input  wire actPkg::addrT memAddr,
    input  wire actPkg::actT  memWdata,
    output logic              getAct,
    output actPkg::actT       actData
);

    actPkg::actT  mem [actPkg::MEM_DEPTH];
    actPkg::addrT rdAddr;
    actPkg::addrT rdSel;
    logic         rewind;

    // A start only counts between layers, when no answer is returning
    assign rewind = sta && !getAct;
    assign rdSel  = rewind ? '0 : rdAddr;   // First word read in the start cycle

    // ====================
    // Memory
    // ====================
    always_ff @(posedge clk) begin
        if (memWe) begin
            mem[memAddr] <= memWdata;
        end
    end

    always_ff @(posedge clk) begin
        if (plsFetch) begin
            actData <= mem[rdSel];
        end
    end

    // ====================
    // Read pointer and answer
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdAddr <= '0;
            getAct <= 1'b0;
        end else begin
            getAct <= plsFetch;             // One cycle behind the request
            if (plsFetch) begin
                rdAddr <= rdSel + 1'b1;     // Wraps at memory depth
            end else if (rewind) begin
                rdAddr <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/actCtrlTop.sv
/*
 * Top level of the activation-fetch slice. Joins the config registers,
 * the loop controller and the fetch unit.
 */
`timescale 1ns/1ps
`default_nettype none

module actCtrlTop (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     sta,
    input  wire logic                     cfgWe,
    input  wire logic [2:0]               cfgAddr,
    input  wire logic [actPkg::CFG_W-1:0] cfgWdata,
    input  wire logic                     memWe,
    input  wire actPkg::addrT             memAddr,
    input  wire actPkg::actT              memWdata,
    output logic                          getAct,
    output actPkg::actT                   actData,
    output logic                          busy,
    output logic                          frtActRow,
    output logic                          lstActRow,
    output logic                          lstActBlk,
    output logic                          valCol,
    output logic                          valPsum,
    output logic                          frtBlk,
    output logic                          fnhFrm,
    output logic                          evenFrm,
    output logic                          poolEn,
    output logic                          poolValDelta,
    output logic                          poolValFrm,
    output logic                          nextPatch,
    output logic                          nextFtrGrp,
    output logic                          layerDone
);

    actPkg::lenT       lenRow;
    actPkg::blkT       numBlk;
    actPkg::frmT       numFrm;
    actPkg::patT       numPat;
    actPkg::grpT       numGrp;
    actPkg::loopOrderT loopOrder;
    logic              plsFetch;

    cfgRegs uCfgRegs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfgWe     (cfgWe),
        .cfgAddr   (cfgAddr),
        .cfgWdata  (cfgWdata),
        .busy      (busy),
        .lenRow    (lenRow),
        .numBlk    (numBlk),
        .numFrm    (numFrm),
        .numPat    (numPat),
        .numGrp    (numGrp),
        .loopOrder (loopOrder)
    );

    actLoopCtrl uActLoopCtrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .sta          (sta),
        .getAct       (getAct),
        .lenRow       (lenRow),
        .numBlk       (numBlk),
        .numFrm       (numFrm),
        .numPat       (numPat),
        .numGrp       (numGrp),
        .loopOrder    (loopOrder),
        .plsFetch     (plsFetch),
        .busy         (busy),
        .frtActRow    (frtActRow),
        .lstActRow    (lstActRow),
        .lstActBlk    (lstActBlk),
        .valCol       (valCol),
        .valPsum      (valPsum),
        .frtBlk       (frtBlk),
        .fnhFrm       (fnhFrm),
        .evenFrm      (evenFrm),
        .poolEn       (poolEn),
        .poolValDelta (poolValDelta),
        .poolValFrm   (poolValFrm),
        .nextPatch    (nextPatch),
        .nextFtrGrp   (nextFtrGrp),
        .layerDone    (layerDone)
    );

    actFetch uActFetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .sta      (sta),
        .plsFetch (plsFetch),
        .memWe    (memWe),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .getAct   (getAct),
        .actData  (actData)
    );

endmodule

`default_nettype wire

//--- test/tbActCtrl.sv
/*
 * Directed testbench for the activation-fetch slice. Each test runs layers through
 * the top level and checks the stream and every strobe against a position model.
 */
`timescale 1ns/1ps
`default_nettype none

module tbActCtrl;

    // Sum of N over all layers below is 596
    localparam int TIMEOUT_CYCLES = 596 + 200;
    localparam int TILE_PATCH     = 1;
    localparam int TILE_GRP       = 2;
    localparam int TILE_DONE      = 3;

    logic                     clk;
    logic                     rst_n;
    logic                     sta;
    logic                     cfgWe;
    logic [2:0]               cfgAddr;
    logic [actPkg::CFG_W-1:0] cfgWdata;
    logic                     memWe;
    actPkg::addrT             memAddr;
    actPkg::actT              memWdata;
    logic                     getAct;
    actPkg::actT              actData;
    logic                     busy;
    logic                     frtActRow;
    logic                     lstActRow;
    logic                     lstActBlk;
    logic                     valCol;
    logic                     valPsum;
    logic                     frtBlk;
    logic                     fnhFrm;
    logic                     evenFrm;
    logic                     poolEn;
    logic                     poolValDelta;
    logic                     poolValFrm;
    logic                     nextPatch;
    logic                     nextFtrGrp;
    logic                     layerDone;

    actPkg::actT memImage [actPkg::MEM_DEPTH]; // Expected memory contents
    int          tileLog[$];                   // Tile pulses seen in the last layer
    int          expTiles [6];
    int          errors = 0;
    int          layerCycles = 0;
    bit          inLayer = 1'b0;

    actCtrlTop uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .sta          (sta),
        .cfgWe        (cfgWe),
        .cfgAddr      (cfgAddr),
        .cfgWdata     (cfgWdata),
        .memWe        (memWe),
        .memAddr      (memAddr),
        .memWdata     (memWdata),
        .getAct       (getAct),
        .actData      (actData),
        .busy         (busy),
        .frtActRow    (frtActRow),
        .lstActRow    (lstActRow),
        .lstActBlk    (lstActBlk),
        .valCol       (valCol),
        .valPsum      (valPsum),
        .frtBlk       (frtBlk),
        .fnhFrm       (fnhFrm),
        .evenFrm      (evenFrm),
        .poolEn       (poolEn),
        .poolValDelta (poolValDelta),
        .poolValFrm   (poolValFrm),
        .nextPatch    (nextPatch),
        .nextFtrGrp   (nextFtrGrp),
        .layerDone    (layerDone)
    );

    always #5 clk = ~clk;

    // ====================
    // Helpers
    // ====================
    task automatic abortRun();
        errors = errors + 1;
        $display("Test failures found");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkWord(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abortRun();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Layer cycle counter for the timeout
    always @(posedge clk) begin
        if (inLayer) begin
            layerCycles = layerCycles + 1;
            if (layerCycles >= TIMEOUT_CYCLES) begin
                $display("Timeout: activation stream did not end within %0d cycles",
                         TIMEOUT_CYCLES);
                abortRun();
            end
        end
    end

    task automatic loadMemory();
        logic [31:0] rng;
        rng = 32'h50991b94;
        for (int i = 0; i < actPkg::MEM_DEPTH; i++) begin
            rng = xorshift32(rng);
            memImage[i] = rng[15:0];
            @(posedge clk);
            memWe    <= 1'b1;
            memAddr  <= actPkg::addrT'(i);
            memWdata <= rng[15:0];
        end
        @(posedge clk);
        memWe <= 1'b0;
    endtask

    task automatic writeCfg(input logic [2:0] addr, input int data);
        @(posedge clk);
        cfgWe    <= 1'b1;
        cfgAddr  <= addr;
        cfgWdata <= 8'(data);
        @(posedge clk);
        cfgWe <= 1'b0;
    endtask

    // ====================
    // Layer run with position model
    // ====================
    task automatic runLayer(input int lr, input int nb, input int nf, input int np,
                            input int ng, input actPkg::loopOrderT ord, input bit poke);
        int n;
        int idx;
        int pAct, pRow, pBlk, pFrm, pPat, pGrp;
        int cntFrt, cntLst, cntBlkEnd, cntFnh;
        bit lastRow, lastBlk, lastFrm, lastTile, lastLay;
        bit expFnh, expNp, expNg, expDone;
        bit done, pokeNow;
        writeCfg(actPkg::REG_LEN_ROW, lr);
        writeCfg(actPkg::REG_NUM_BLK, nb);
        writeCfg(actPkg::REG_NUM_FRM, nf);
        writeCfg(actPkg::REG_NUM_PAT, np);
        writeCfg(actPkg::REG_NUM_GRP, ng);
        writeCfg(actPkg::REG_LOOP_ORD, int'(ord));
        n = (lr + 1) * (lr + 1) * (nb + 1) * (nf + 1) * (np + 1) * (ng + 1);
        {idx, pAct, pRow, pBlk, pFrm, pPat, pGrp} = '0;
        {cntFrt, cntLst, cntBlkEnd, cntFnh} = '0;
        {expFnh, expNp, expNg, expDone, done} = '0;
        tileLog.delete();
        @(posedge clk);
        sta     <= 1'b1;
        inLayer = 1'b1;
        while (!done) begin
            @(posedge clk);
            pokeNow = poke && (idx == 4);      // Restart and rewrite mid-layer
            sta      <= pokeNow;
            cfgWe    <= pokeNow;
            cfgAddr  <= actPkg::REG_LEN_ROW;
            cfgWdata <= 8'd1;
            @(negedge clk);
            // Registered pulses from the previous activation
            checkBit("fnhFrm", fnhFrm, expFnh);
            checkBit("nextPatch", nextPatch, expNp);
            checkBit("nextFtrGrp", nextFtrGrp, expNg);
            checkBit("layerDone", layerDone, expDone);
            checkBit("busy", busy, !expDone);
            checkBit("getAct", getAct, idx < n);
            if (nextPatch) tileLog.push_back(TILE_PATCH);
            if (nextFtrGrp) tileLog.push_back(TILE_GRP);
            if (layerDone) tileLog.push_back(TILE_DONE);
            cntFnh = cntFnh + int'(fnhFrm);
            done = layerDone;
            {expFnh, expNp, expNg, expDone} = '0;
            if (getAct) begin
                checkWord("actData", 32'(actData), 32'(memImage[idx % 256]));
                checkBit("frtActRow", frtActRow, pAct == 0);
                checkBit("lstActRow", lstActRow, pAct == lr);
                checkBit("lstActBlk", lstActBlk, pAct == lr && pRow == lr);
                checkBit("valCol", valCol, pAct >= 2);
                checkBit("valPsum", valPsum, pRow >= 2);
                checkBit("frtBlk", frtBlk, pBlk == 0);
                checkBit("evenFrm", evenFrm, pFrm % 2 == 0);
                checkBit("poolValDelta", poolValDelta, pFrm >= 2);
                checkBit("poolValFrm", poolValFrm, pFrm % 2 == 0 && pFrm >= 2);
                checkBit("poolEn", poolEn,
                         pAct == 0 && pRow == 0 && pBlk != 0 && pFrm != 0);
                cntFrt    = cntFrt + int'(frtActRow);
                cntLst    = cntLst + int'(lstActRow);
                cntBlkEnd = cntBlkEnd + int'(lstActBlk);
                // Advance the model position
                lastRow  = (pAct == lr);
                lastBlk  = lastRow && (pRow == lr);
                lastFrm  = lastBlk && (pBlk == nb);
                lastTile = lastFrm && (pFrm == nf);
                lastLay  = lastTile && (pPat == np) && (pGrp == ng);
                pAct = lastRow ? 0 : pAct + 1;
                if (lastRow) pRow = lastBlk ? 0 : pRow + 1;
                if (lastBlk) pBlk = lastFrm ? 0 : pBlk + 1;
                if (lastFrm) pFrm = lastTile ? 0 : pFrm + 1;
                expFnh  = lastFrm && !lastLay;
                expDone = lastLay;
                if (lastTile && !lastLay) begin
                    if (ord == actPkg::PATCH_INNER) begin
                        if (pPat < np) begin
                            pPat  = pPat + 1;
                            expNp = 1'b1;
                        end else begin
                            pPat  = 0;
                            pGrp  = pGrp + 1;
                            expNg = 1'b1;
                        end
                    end else if (pGrp < ng) begin
                        pGrp  = pGrp + 1;
                        expNg = 1'b1;
                    end else begin
                        pGrp  = 0;
                        pPat  = pPat + 1;
                        expNp = 1'b1;
                    end
                end
                idx = idx + 1;
            end
        end
        inLayer = 1'b0;
        checkWord("getAct count", idx, n);
        checkWord("frtActRow count", cntFrt, n / (lr + 1));
        checkWord("lstActRow count", cntLst, n / (lr + 1));
        checkWord("lstActBlk count", cntBlkEnd, n / ((lr + 1) * (lr + 1)));
        checkWord("fnhFrm count", cntFnh, (nf + 1) * (np + 1) * (ng + 1) - 1);
    endtask

    task automatic compareTiles();
        checkWord("tile pulse count", tileLog.size(), 6);
        foreach (expTiles[i]) begin
            checkWord("tile pulse code", tileLog[i], expTiles[i]);
        end
    endtask

    // ====================
    // Tests
    // ====================
    task automatic testStreamOrder();
        runLayer(4, 2, 1, 1, 0, actPkg::PATCH_INNER, 1'b0); // 300 words, wraps memory
    endtask

    task automatic testRowBlockStrobes();
        runLayer(2, 1, 2, 0, 0, actPkg::PATCH_INNER, 1'b0);
    endtask

    task automatic testFramePooling();
        runLayer(1, 2, 4, 0, 1, actPkg::PATCH_INNER, 1'b0); // Five frames per tile
    endtask

    task automatic testPatchInner();
        runLayer(1, 0, 1, 2, 1, actPkg::PATCH_INNER, 1'b0);
        expTiles = '{TILE_PATCH, TILE_PATCH, TILE_GRP, TILE_PATCH, TILE_PATCH, TILE_DONE};
        compareTiles();
    endtask

    task automatic testFtrGrpInner();
        runLayer(1, 0, 1, 2, 1, actPkg::FTRGRP_INNER, 1'b0);
        expTiles = '{TILE_GRP, TILE_PATCH, TILE_GRP, TILE_PATCH, TILE_GRP, TILE_DONE};
        compareTiles();
    endtask

    task automatic testCfgLock();
        runLayer(2, 0, 0, 1, 0, actPkg::PATCH_INNER, 1'b1); // Length must stay 18
        runLayer(1, 0, 0, 1, 0, actPkg::PATCH_INNER, 1'b0); // New length 8
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        sta      = 1'b0;
        cfgWe    = 1'b0;
        cfgAddr  = '0;
        cfgWdata = '0;
        memWe    = 1'b0;
        memAddr  = '0;
        memWdata = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        loadMemory();
        testStreamOrder();
        testRowBlockStrobes();
        testFramePooling();
        testPatchInner();
        testFtrGrpInner();
        testCfgLock();
        repeat (2) @(posedge clk);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
common/actPkg.sv
src/cfgRegs.sv
ctrlAct/actLoopCtrl.sv
src/actFetch.sv
src/actCtrlTop.sv
test/tbActCtrl.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the activation controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module tbActCtrl \
    -Mdir obj_dir -o simv \
    && ./obj_dir/simv | tee sim.log \
    || { echo "Build or simulation failed"; exit 1; }
grep -q 'All tests passed!' sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
